// File: common/rvCorePkg.sv
package rvCorePkg;

    // RV32 major opcodes handled here
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opReg    = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // func7 patterns for OP and the immediate shifts
    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;
    localparam logic [6:0] f7MulDiv = 7'b0000001;

    // Branch conditions in func3
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // ALU operations
    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd,
        aluMul,
        // Operand B straight through for LUI
        aluPassB
    } aluOpE;

    // Decode to execute
    typedef struct packed {
        logic        valid;
        logic        illegal;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        logic [2:0]  func3;
        // Sign extended I, U or B immediate
        logic [31:0] imm;
        logic [31:0] pc;
        aluOpE       aluOp;
        // Immediate as operand B
        logic        aluSrcImm;
        // PC as operand A for AUIPC
        logic        aluSrcPc;
        logic        regWrite;
        logic        isBranch;
    } decodedT;

    // Writeback stage contents
    typedef struct packed {
        logic        valid;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        branchValid;
        logic        branchTaken;
        logic [31:0] branchTarget;
        logic        illegal;
    } wbT;

endpackage

// File: decode/instrDecoder.sv
module instrDecoder import rvCorePkg::*;
#(
    parameter int numRegs = 32
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] instrPc,
    output decodedT     dec
);

    // Instruction register
    logic        validQ;
    logic [31:0] instrQ;
    logic [31:0] pcQ;

    // Raw fields
    logic [6:0]  opcode;
    logic [6:0]  func7;
    logic [2:0]  func3;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;

    // Immediate candidates
    logic [31:0] immI;
    logic [31:0] immU;
    logic [31:0] immB;

    // Control before legality masking
    logic        opLegal;
    logic        usesRd;
    logic        usesRs1;
    logic        usesRs2;
    logic        branchOp;
    logic        regBad;
    logic        bad;

    // Common func3 mapping for OP and OP-IMM in base func7 form
    function automatic aluOpE baseAluOp(input logic [2:0] f3);
        aluOpE op;
        case (f3)
            3'b000:  op = aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            validQ <= 1'b0;
            instrQ <= '0;
            pcQ    <= '0;
        end
        else
        begin
            // Sampled every edge
            // validQ marks a real slot
            validQ <= instrValid;
            instrQ <= instr;
            pcQ    <= instrPc;
        end
    end

    assign opcode = instrQ[6:0];
    assign rd     = instrQ[11:7];
    assign func3  = instrQ[14:12];
    assign rs1    = instrQ[19:15];
    assign rs2    = instrQ[24:20];
    assign func7  = instrQ[31:25];

    assign immI = {{20{instrQ[31]}}, instrQ[31:20]};
    assign immU = {instrQ[31:12], 12'b0};
    // B format scatters bits with the LSB always zero
    assign immB = {{19{instrQ[31]}}, instrQ[31], instrQ[7], instrQ[30:25],
                   instrQ[11:8], 1'b0};

    always_comb
    begin
        // Defaults describe an unsupported opcode
        opLegal          = 1'b0;
        usesRd           = 1'b0;
        usesRs1          = 1'b0;
        usesRs2          = 1'b0;
        branchOp         = 1'b0;
        dec.aluOp        = aluAdd;
        dec.aluSrcImm    = 1'b0;
        dec.aluSrcPc     = 1'b0;
        dec.imm          = immI;

        case (opcode)
            opLui:
            begin
                opLegal       = 1'b1;
                usesRd        = 1'b1;
                dec.aluOp     = aluPassB;
                dec.aluSrcImm = 1'b1;
                dec.imm       = immU;
            end
            opAuipc:
            begin
                opLegal       = 1'b1;
                usesRd        = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluSrcPc  = 1'b1;
                dec.imm       = immU;
            end
            opImm:
            begin
                usesRd        = 1'b1;
                usesRs1       = 1'b1;
                dec.aluSrcImm = 1'b1;
                dec.aluOp     = baseAluOp(func3);
                // Shift forms constrain the upper immediate bits
                if (func3 == 3'b001)
                    opLegal = (func7 == f7Base);
                else if (func3 == 3'b101)
                begin
                    opLegal = (func7 == f7Base) || (func7 == f7Alt);
                    if (func7 == f7Alt)
                        dec.aluOp = aluSra;
                end
                else
                    opLegal = 1'b1;
            end
            opReg:
            begin
                usesRd  = 1'b1;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (func7)
                    f7Base:
                    begin
                        opLegal   = 1'b1;
                        dec.aluOp = baseAluOp(func3);
                    end
                    f7Alt:
                    begin
                        // Bit 30 only valid for SUB and SRA
                        opLegal   = (func3 == 3'b000) || (func3 == 3'b101);
                        dec.aluOp = (func3 == 3'b000) ? aluSub : aluSra;
                    end
                    f7MulDiv:
                    begin
                        // Only MUL here
                        // MULH and DIV families stay illegal
                        opLegal   = (func3 == 3'b000);
                        dec.aluOp = aluMul;
                    end
                    default:
                        opLegal = 1'b0;
                endcase
            end
            opBranch:
            begin
                usesRs1  = 1'b1;
                usesRs2  = 1'b1;
                branchOp = 1'b1;
                dec.imm  = immB;
                // func3 010 and 011 are reserved
                opLegal  = (func3 != 3'b010) && (func3 != 3'b011);
            end
            default:
                opLegal = 1'b0;
        endcase

        // Register indices past the configured bank
        regBad = (usesRd && (rd >= numRegs)) ||
                 (usesRs1 && (rs1 >= numRegs)) ||
                 (usesRs2 && (rs2 >= numRegs));
        bad    = !opLegal || regBad;

        dec.valid    = validQ;
        dec.illegal  = validQ && bad;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = rd;
        dec.func3    = func3;
        dec.pc       = pcQ;
        dec.regWrite = validQ && !bad && usesRd;
        dec.isBranch = validQ && !bad && branchOp;
    end

endmodule

// File: verilog/regFile.sv
module regFile
#(
    parameter int numRegs = 32
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    // x0 has no storage
    logic [31:0] regs [1:numRegs-1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 1; i < numRegs; i++)
                regs[i] <= '0;
        end
        else if (wrEn && (wrAddr != 5'd0) && (wrAddr < numRegs))
        begin
            regs[wrAddr] <= wrData;
        end
    end

    // Zero and out of range indices read as zero
    always_comb
    begin
        rdDataA = '0;
        rdDataB = '0;
        if ((rdAddrA != 5'd0) && (rdAddrA < numRegs))
            rdDataA = regs[rdAddrA];
        if ((rdAddrB != 5'd0) && (rdAddrB < numRegs))
            rdDataB = regs[rdAddrB];
    end

endmodule

// File: execute/aluUnit.sv
module aluUnit import rvCorePkg::*;
(
    input  decodedT     dec,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    output logic [31:0] result
);

    logic [31:0] opA;
    logic [31:0] opB;
    logic [4:0]  shamt;
    logic        ltSigned;
    logic        ltUnsigned;

    // PC as A for AUIPC only
    assign opA = dec.aluSrcPc ? dec.pc : rs1Data;
    // Immediate as B for OP-IMM, LUI, AUIPC
    assign opB = dec.aluSrcImm ? dec.imm : rs2Data;

    // Shift amount from low five bits of B
    assign shamt = opB[4:0];

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    always_comb
    begin
        case (dec.aluOp)
            aluAdd:
                result = opA + opB;
            aluSub:
                result = opA - opB;
            aluSll:
                result = opA << shamt;
            aluSlt:
                result = {31'b0, ltSigned};
            aluSltu:
                result = {31'b0, ltUnsigned};
            aluXor:
                result = opA ^ opB;
            aluSrl:
                result = opA >> shamt;
            aluSra:
                // Arithmetic shift keeps the sign
                result = $unsigned($signed(opA) >>> shamt);
            aluOr:
                result = opA | opB;
            aluAnd:
                result = opA & opB;
            aluMul:
                // Low half of the product is sign independent
                result = opA * opB;
            aluPassB:
                result = opB;
            default:
                result = '0;
        endcase
    end

endmodule

// File: execute/branchUnit.sv
module branchUnit import rvCorePkg::*;
(
    input  decodedT     dec,
    input  logic [31:0] rs1Data,
    input  logic [31:0] rs2Data,
    output logic        taken,
    output logic [31:0] target
);

    logic eq;
    logic ltSigned;
    logic ltUnsigned;
    logic cond;

    assign eq         = rs1Data == rs2Data;
    assign ltSigned   = $signed(rs1Data) < $signed(rs2Data);
    assign ltUnsigned = rs1Data < rs2Data;

    // Condition by func3
    always_comb
    begin
        case (dec.func3)
            f3Beq:   cond = eq;
            f3Bne:   cond = !eq;
            f3Blt:   cond = ltSigned;
            f3Bge:   cond = !ltSigned;
            f3Bltu:  cond = ltUnsigned;
            f3Bgeu:  cond = !ltUnsigned;
            default: cond = 1'b0;
        endcase
    end

    // Only a legal branch can report taken
    assign taken = dec.isBranch && cond;

    // Computed whether taken or not
    assign target = dec.pc + dec.imm;

endmodule

// File: verilog/execCore.sv
module execCore import rvCorePkg::*;
#(
    parameter int numRegs = 32
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    input  logic [31:0] instr,
    input  logic [31:0] instrPc,
    output logic        wbValid,
    output logic [4:0]  wbRd,
    output logic [31:0] wbData,
    output logic        brValid,
    output logic        brTaken,
    output logic [31:0] brTarget,
    output logic        illegalInstr
);

    decodedT     dec;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] aluResult;
    logic        brTakenNext;
    logic [31:0] brTargetNext;
    wbT          wbNext;
    wbT          wbQ;

    instrDecoder #(.numRegs(numRegs)) decoder0 (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instr      (instr),
        .instrPc    (instrPc),
        .dec        (dec)
    );

    // Written from the writeback register one edge after it loads
    regFile #(.numRegs(numRegs)) regFile0 (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (dec.rs1),
        .rdAddrB (dec.rs2),
        .rdDataA (rs1Data),
        .rdDataB (rs2Data),
        .wrEn    (wbQ.valid),
        .wrAddr  (wbQ.rd),
        .wrData  (wbQ.data)
    );

    aluUnit alu0 (
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .result  (aluResult)
    );

    branchUnit branch0 (
        .dec     (dec),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .taken   (brTakenNext),
        .target  (brTargetNext)
    );

    // Pack stage results
    // regWrite already excludes branches and illegal ops
    always_comb
    begin
        wbNext.valid        = dec.valid && dec.regWrite;
        wbNext.rd           = dec.rd;
        wbNext.data         = aluResult;
        wbNext.branchValid  = dec.isBranch;
        wbNext.branchTaken  = brTakenNext;
        wbNext.branchTarget = brTargetNext;
        wbNext.illegal      = dec.illegal;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            wbQ <= '0;
        else
            wbQ <= wbNext;
    end

    // Output ports straight from the writeback register
    assign wbValid      = wbQ.valid;
    assign wbRd         = wbQ.rd;
    assign wbData       = wbQ.data;
    assign brValid      = wbQ.branchValid;
    assign brTaken      = wbQ.branchTaken;
    assign brTarget     = wbQ.branchTarget;
    assign illegalInstr = wbQ.illegal;

endmodule

// File: dv/wbChecker.sv
module wbChecker
(
    input  logic        clk,
    input  logic        rst,
    // Expected row already delayed to line up with the DUT outputs
    input  logic        expWrite,
    input  logic        expBranch,
    input  logic        expIllegal,
    input  logic [4:0]  expRd,
    input  logic [31:0] expData,
    input  logic        expTaken,
    input  logic [31:0] expTarget,
    // DUT outputs
    input  logic        wbValid,
    input  logic [4:0]  wbRd,
    input  logic [31:0] wbData,
    input  logic        brValid,
    input  logic        brTaken,
    input  logic [31:0] brTarget,
    input  logic        illegalInstr,
    output int          valueErrors,
    output int          pulseErrors
);

    initial
    begin
        valueErrors = 0;
        pulseErrors = 0;
    end

    // Wrong data on a pulse that did come
    task automatic compareValue(input string name, input logic [31:0] expV,
                                input logic [31:0] actV);
        if (actV !== expV)
        begin
            valueErrors++;
            $display("** Error at time %0t: %s expected %0h, got %0h", $time, name, expV, actV);
        end
    endtask

    // Pulse present where none belongs or missing
    task automatic expectPulse(input string name, input logic expV, input logic actV);
        if (actV !== expV)
        begin
            pulseErrors++;
            if (expV)
                $display("At time %0t %s stayed low where a pulse was expected", $time, name);
            else
                $display("At time %0t %s pulsed where none was expected", $time, name);
        end
    endtask

    // Registered outputs are stable at mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            expectPulse("wbValid", expWrite, wbValid);
            expectPulse("brValid", expBranch, brValid);
            expectPulse("illegalInstr", expIllegal, illegalInstr);
            if (expWrite && wbValid)
            begin
                compareValue("wbRd", {27'b0, expRd}, {27'b0, wbRd});
                compareValue("wbData", expData, wbData);
            end
            // Target checked for taken and not taken alike
            if (expBranch && brValid)
            begin
                compareValue("brTaken", {31'b0, expTaken}, {31'b0, brTaken});
                compareValue("brTarget", expTarget, brTarget);
            end
        end
    end

endmodule

// File: dv/execCoreTb.sv
module execCoreTb import rvCorePkg::*;
();

    localparam int resetCycles = 10;

    // Row kinds
    localparam logic [1:0] kindNone    = 2'd0;
    localparam logic [1:0] kindWrite   = 2'd1;
    localparam logic [1:0] kindBranch  = 2'd2;
    localparam logic [1:0] kindIllegal = 2'd3;

    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
        logic [31:0] pc;
        logic [1:0]  kind;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        taken;
        logic [31:0] target;
    } rowT;

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] instrPc;
    logic        wbValid;
    logic [4:0]  wbRd;
    logic [31:0] wbData;
    logic        brValid;
    logic        brTaken;
    logic [31:0] brTarget;
    logic        illegalInstr;
    int          valueErrors;
    int          pulseErrors;

    rowT         stimRows[$];
    logic [31:0] rowPc;
    // Expectation pipe two edges behind the issue slot
    rowT         issueRow;
    rowT         expMid;
    rowT         expOut;
    int          cycleCount = 0;
    int          cycleLimit = 0;

    always #50 clk = ~clk;

    execCore #(.numRegs(32)) dut0 (
        .clk          (clk),
        .rst          (rst),
        .instrValid   (instrValid),
        .instr        (instr),
        .instrPc      (instrPc),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData),
        .brValid      (brValid),
        .brTaken      (brTaken),
        .brTarget     (brTarget),
        .illegalInstr (illegalInstr)
    );

    wbChecker checker0 (
        .clk          (clk),
        .rst          (rst),
        .expWrite     (expOut.kind == kindWrite),
        .expBranch    (expOut.kind == kindBranch),
        .expIllegal   (expOut.kind == kindIllegal),
        .expRd        (expOut.rd),
        .expData      (expOut.data),
        .expTaken     (expOut.taken),
        .expTarget    (expOut.target),
        .wbValid      (wbValid),
        .wbRd         (wbRd),
        .wbData       (wbData),
        .brValid      (brValid),
        .brTaken      (brTaken),
        .brTarget     (brTarget),
        .illegalInstr (illegalInstr),
        .valueErrors  (valueErrors),
        .pulseErrors  (pulseErrors)
    );

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            expMid <= '0;
            expOut <= '0;
        end
        else
        begin
            expMid <= issueRow;
            expOut <= expMid;
        end
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    // Instruction encoders
    function automatic logic [31:0] iFormat(input logic [11:0] imm, input int rs1,
                                            input logic [2:0] f3, input int rd,
                                            input logic [6:0] op);
        return {imm, rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] rFormat(input logic [6:0] f7, input int rs2,
                                            input int rs1, input logic [2:0] f3,
                                            input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], opReg};
    endfunction

    function automatic logic [31:0] uFormat(input logic [19:0] imm, input int rd,
                                            input logic [6:0] op);
        return {imm, rd[4:0], op};
    endfunction

    // B immediate bit 0 is implied
    function automatic logic [31:0] bFormat(input logic [12:0] imm, input int rs1,
                                            input int rs2, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], opBranch};
    endfunction

    task automatic writeRow(input logic [31:0] ins, input int rd, input logic [31:0] data);
        rowT r;
        r       = '0;
        r.valid = 1'b1;
        r.instr = ins;
        r.pc    = rowPc;
        r.kind  = kindWrite;
        r.rd    = rd[4:0];
        r.data  = data;
        stimRows.push_back(r);
        rowPc   = rowPc + 32'd4;
    endtask

    task automatic branchRow(input logic [31:0] ins, input logic taken,
                             input logic [31:0] target);
        rowT r;
        r        = '0;
        r.valid  = 1'b1;
        r.instr  = ins;
        r.pc     = rowPc;
        r.kind   = kindBranch;
        r.taken  = taken;
        r.target = target;
        stimRows.push_back(r);
        rowPc    = rowPc + 32'd4;
    endtask

    task automatic illegalRow(input logic [31:0] ins);
        rowT r;
        r       = '0;
        r.valid = 1'b1;
        r.instr = ins;
        r.pc    = rowPc;
        r.kind  = kindIllegal;
        stimRows.push_back(r);
        rowPc   = rowPc + 32'd4;
    endtask

    // Idle slot with instrValid low
    task automatic gapRow();
        rowT r;
        r      = '0;
        r.kind = kindNone;
        stimRows.push_back(r);
    endtask

    task automatic buildTable();
        // Quiet after reset before x3 reads back as zero
        gapRow();
        gapRow();
        writeRow(iFormat(12'h000, 3, 3'b000, 5, opImm), 5, 32'h0000_0000);
        // LUI, AUIPC and OP-IMM
        writeRow(uFormat(20'h12345, 1, opLui), 1, 32'h1234_5000);
        writeRow(uFormat(20'h00001, 2, opAuipc), 2, rowPc + 32'h0000_1000);
        writeRow(iFormat(12'hFFB, 0, 3'b000, 3, opImm), 3, 32'hFFFF_FFFB);
        writeRow(iFormat(12'hFFF, 1, 3'b000, 4, opImm), 4, 32'h1234_4FFF);
        writeRow(iFormat(12'hFFC, 3, 3'b010, 6, opImm), 6, 32'h0000_0001);
        writeRow(iFormat(12'h005, 3, 3'b011, 7, opImm), 7, 32'h0000_0000);
        writeRow(iFormat(12'h0FF, 1, 3'b100, 8, opImm), 8, 32'h1234_50FF);
        writeRow(iFormat(12'h004, 3, 3'b110, 9, opImm), 9, 32'hFFFF_FFFF);
        writeRow(iFormat(12'h7F0, 8, 3'b111, 10, opImm), 10, 32'h0000_00F0);
        writeRow(iFormat(12'h004, 6, 3'b001, 11, opImm), 11, 32'h0000_0010);
        writeRow(iFormat(12'h01C, 3, 3'b101, 12, opImm), 12, 32'h0000_000F);
        writeRow(iFormat(12'h401, 3, 3'b101, 13, opImm), 13, 32'hFFFF_FFFD);
        gapRow();
        // R type results consumed two slots later
        writeRow(rFormat(f7Base, 11, 13, 3'b000, 14), 14, 32'h0000_000D);
        writeRow(rFormat(f7Base, 3, 6, 3'b011, 15), 15, 32'h0000_0001);
        writeRow(rFormat(f7Alt, 6, 14, 3'b000, 16), 16, 32'h0000_000C);
        writeRow(rFormat(f7Base, 9, 15, 3'b100, 17), 17, 32'hFFFF_FFFE);
        writeRow(rFormat(f7Base, 6, 16, 3'b001, 18), 18, 32'h0000_0018);
        writeRow(rFormat(f7Base, 11, 17, 3'b101, 19), 19, 32'h0000_FFFF);
        writeRow(rFormat(f7Base, 18, 3, 3'b010, 20), 20, 32'h0000_0001);
        writeRow(rFormat(f7Alt, 19, 13, 3'b101, 21), 21, 32'hFFFF_FFFF);
        writeRow(rFormat(f7Base, 20, 18, 3'b110, 22), 22, 32'h0000_0019);
        writeRow(rFormat(f7Base, 16, 21, 3'b111, 23), 23, 32'h0000_000C);
        writeRow(rFormat(f7MulDiv, 3, 22, 3'b000, 24), 24, 32'hFFFF_FF83);
        writeRow(rFormat(f7MulDiv, 23, 1, 3'b000, 25), 25, 32'hDA73_C000);
        writeRow(rFormat(f7Alt, 24, 0, 3'b000, 26), 26, 32'h0000_007D);
        writeRow(rFormat(f7MulDiv, 11, 25, 3'b000, 27), 27, 32'hA73C_0000);
        writeRow(rFormat(f7MulDiv, 3, 24, 3'b000, 28), 28, 32'h0000_0271);
        // Branches on x6 = x20 = 1 and x3 = -5
        branchRow(bFormat(13'd16, 6, 20, f3Beq), 1'b1, rowPc + 32'd16);
        branchRow(bFormat(13'h1FF8, 3, 6, f3Beq), 1'b0, rowPc - 32'd8);
        branchRow(bFormat(13'd8, 6, 20, f3Bne), 1'b0, rowPc + 32'd8);
        branchRow(bFormat(13'h1000, 3, 6, f3Bne), 1'b1, rowPc - 32'd4096);
        branchRow(bFormat(13'h0FFE, 3, 6, f3Blt), 1'b1, rowPc + 32'd4094);
        branchRow(bFormat(13'h100, 6, 3, f3Blt), 1'b0, rowPc + 32'h100);
        branchRow(bFormat(13'd16, 6, 20, f3Blt), 1'b0, rowPc + 32'd16);
        branchRow(bFormat(13'h1FF8, 6, 20, f3Bge), 1'b1, rowPc - 32'd8);
        branchRow(bFormat(13'd8, 3, 6, f3Bge), 1'b0, rowPc + 32'd8);
        branchRow(bFormat(13'h1000, 6, 3, f3Bge), 1'b1, rowPc - 32'd4096);
        branchRow(bFormat(13'h0FFE, 3, 6, f3Bltu), 1'b0, rowPc + 32'd4094);
        branchRow(bFormat(13'h100, 6, 3, f3Bltu), 1'b1, rowPc + 32'h100);
        branchRow(bFormat(13'd16, 6, 20, f3Bltu), 1'b0, rowPc + 32'd16);
        branchRow(bFormat(13'h1FF8, 3, 6, f3Bgeu), 1'b1, rowPc - 32'd8);
        branchRow(bFormat(13'd8, 6, 3, f3Bgeu), 1'b0, rowPc + 32'd8);
        branchRow(bFormat(13'h1000, 6, 20, f3Bgeu), 1'b1, rowPc - 32'd4096);
        // x0 write shows data while x0 still reads zero
        writeRow(iFormat(12'h123, 1, 3'b000, 0, opImm), 0, 32'h1234_5123);
        gapRow();
        writeRow(rFormat(f7Base, 6, 0, 3'b000, 27), 27, 32'h0000_0001);
        // Load, JAL, bad func7 and MULH with each target register read back after a gap
        illegalRow(iFormat(12'h000, 1, 3'b010, 6, 7'b0000011));
        gapRow();
        writeRow(iFormat(12'h000, 6, 3'b000, 28, opImm), 28, 32'h0000_0001);
        illegalRow(uFormat(20'h00100, 8, 7'b1101111));
        gapRow();
        writeRow(iFormat(12'h000, 8, 3'b000, 29, opImm), 29, 32'h1234_50FF);
        illegalRow(rFormat(7'b0010000, 6, 3, 3'b000, 9));
        gapRow();
        writeRow(iFormat(12'h000, 9, 3'b000, 30, opImm), 30, 32'hFFFF_FFFF);
        illegalRow(rFormat(f7MulDiv, 6, 3, 3'b001, 10));
        gapRow();
        writeRow(iFormat(12'h000, 10, 3'b000, 31, opImm), 31, 32'h0000_00F0);
    endtask

    initial
    begin
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        instrPc    = '0;
        issueRow   = '0;
        rowPc      = 32'h0000_1000;
        buildTable();
        cycleLimit = stimRows.size() + resetCycles + 20;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
        // One row per cycle
        foreach (stimRows[i])
        begin
            @(posedge clk);
            instrValid <= stimRows[i].valid;
            instr      <= stimRows[i].instr;
            instrPc    <= stimRows[i].pc;
            issueRow   <= stimRows[i];
        end
        @(posedge clk);
        instrValid <= 1'b0;
        issueRow   <= '0;
        // Last row reaches the outputs two edges after issue
        repeat (2) @(posedge clk);
        $display("%0d value errors, %0d pulse errors", valueErrors, pulseErrors);
        if ((valueErrors == 0) && (pulseErrors == 0))
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog
    initial
    begin
        wait (cycleLimit > 0);
        wait (cycleCount >= cycleLimit);
        $display("Timeout after %0d cycles, the stimulus table did not drain", cycleCount);
        $display("%0d value errors, %0d pulse errors", valueErrors, pulseErrors);
        $display("tests failed");
        $finish;
    end

endmodule

// File: all.f
common/rvCorePkg.sv
decode/instrDecoder.sv
verilog/regFile.sv
execute/aluUnit.sv
execute/branchUnit.sv
verilog/execCore.sv
dv/wbChecker.sv
dv/execCoreTb.sv
